// File: flist.f
+incdir+common
common/hwpe_pkg.sv
reorder/tcdm_reorder_static.sv
design/order_regs.sv
design/tcdm_bank.sv
design/tcdm_cluster_top.sv
tb/tb_tcdm_cluster.sv

// File: Makefile
# Verilator flow for the TCDM memory cluster testbench

VERILATOR ?= verilator
TOP       ?= tb_tcdm_cluster
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard common/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then echo "Simulation incomplete"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/tb_tcdm_cluster.sv
`include "hwpe_cfg.svh"

module tb_tcdm_cluster;

  import hwpe_pkg::*;

  localparam int NB      = `HWPE_NB_CHAN;
  localparam int DW      = `HWPE_DATA_W;
  localparam int BE_W    = `HWPE_DATA_W / 8;
  // Narrow address window so that reads keep hitting earlier writes
  localparam int WORDS   = 16;
  localparam int TIMEOUT = 20;

  logic                 clk_i;
  logic                 arst_n_i;
  tcdm_req_t  [NB-1:0]  tcdm_req;
  tcdm_resp_t [NB-1:0]  tcdm_resp;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  logic                 wb_adr;
  logic [DW-1:0]        wb_wdat;
  logic [BE_W-1:0]      wb_sel;
  logic [DW-1:0]        wb_rdat;
  logic                 wb_ack;
  logic                 wb_err;

  // Model of the cluster: current order, bank words, and the bytes known so far
  order_t               model_order;
  logic [DW-1:0]        model_mem [NB][`HWPE_BANK_WORDS];
  logic [BE_W-1:0]      model_vld [NB][`HWPE_BANK_WORDS];
  // Per channel, {byte mask, word} expected for every granted read
  logic [BE_W+DW-1:0]   exp_q [NB][$];
  logic [31:0]          rnd_state;

  tcdm_cluster_top u_tcdm_cluster_top (
    .clk_i       ( clk_i     ),
    .arst_n_i    ( arst_n_i  ),
    .tcdm_req_i  ( tcdm_req  ),
    .tcdm_resp_o ( tcdm_resp ),
    .wb_cyc_i    ( wb_cyc    ),
    .wb_stb_i    ( wb_stb    ),
    .wb_we_i     ( wb_we     ),
    .wb_adr_i    ( wb_adr    ),
    .wb_dat_i    ( wb_wdat   ),
    .wb_sel_i    ( wb_sel    ),
    .wb_dat_o    ( wb_rdat   ),
    .wb_ack_o    ( wb_ack    ),
    .wb_err_o    ( wb_err    )
  );

  initial begin : clk_gen
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rnd_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rnd_state = x;
    return x;
  endfunction

  task automatic stop_on_error();
    $display("Verification failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Bank j serves channel order[j], so search the model order for the channel
  function automatic int bank_of(chan_idx_t chan);
    int bank;
    bank = 0;
    for (int j = 0; j < NB; j++) begin
      if (model_order[j] == chan) begin
        bank = j;
      end
    end
    return bank;
  endfunction

  // Expected read word for a channel, with the mask of bytes that were written
  function automatic logic [BE_W+DW-1:0] ref_read(chan_idx_t chan, logic [31:0] add);
    int bank;
    int word;
    bank = bank_of(chan);
    word = int'(add >> 2);
    return {model_vld[bank][word], model_mem[bank][word]};
  endfunction

  function automatic void model_write(chan_idx_t chan, tcdm_req_t r);
    int bank;
    int word;
    bank = bank_of(chan);
    word = int'(r.add >> 2);
    for (int b = 0; b < BE_W; b++) begin
      if (r.be[b]) begin
        model_mem[bank][word][8*b +: 8] = r.data[8*b +: 8];
        model_vld[bank][word][b]        = 1'b1;
      end
    end
  endfunction

  function automatic tcdm_req_t make_req(logic rd, int word, logic [BE_W-1:0] be,
                                         logic [DW-1:0] data);
    tcdm_req_t r;
    r.req  = 1'b1;
    r.add  = 32'(word * BE_W);
    r.wen  = rd;
    r.be   = be;
    r.data = data;
    return r;
  endfunction

  function automatic tcdm_req_t rand_req();
    tcdm_req_t   r;
    logic [31:0] x;
    x = xorshift();
    r = make_req(x[0], int'(x[15:8]) % WORDS, x[4 +: BE_W], xorshift());
    if (r.be == '0) begin
      r.be = '1;
    end
    return r;
  endfunction

  // Fisher-Yates shuffle, forced away from the identity
  function automatic order_t random_perm();
    order_t    p;
    chan_idx_t t;
    int        k;
    for (int j = 0; j < NB; j++) begin
      p[j] = chan_idx_t'(j);
    end
    for (int j = NB - 1; j > 0; j--) begin
      k    = int'(xorshift() % 32'(j + 1));
      t    = p[j];
      p[j] = p[k];
      p[k] = t;
    end
    if (p[0] == chan_idx_t'(0) && p[1] == chan_idx_t'(1)) begin
      t    = p[0];
      p[0] = p[1];
      p[1] = t;
    end
    return p;
  endfunction

  task automatic check_resp(input int chan, input tcdm_resp_t got, input tcdm_resp_t want,
                            input logic [BE_W-1:0] mask);
    logic [DW-1:0] m;
    for (int b = 0; b < BE_W; b++) begin
      m[8*b +: 8] = {8{mask[b]}};
    end
    if (got.r_valid !== want.r_valid) begin
      $display("[ERROR] tcdm_resp_o[%0d].r_valid got %h expected %h", chan, got.r_valid,
               want.r_valid);
      stop_on_error();
    end
    if (want.r_valid && ((got.r_data & m) !== (want.r_data & m))) begin
      $display("[ERROR] tcdm_resp_o[%0d].r_data got %h expected %h mask %h", chan,
               got.r_data, want.r_data, m);
      stop_on_error();
    end
  endtask

  // The whole bus word is compared, so the bits above the order must read zero
  task automatic check_order(input logic [DW-1:0] got, input order_t want);
    if (got !== DW'(want)) begin
      $display("[ERROR] wb_dat_o got %h expected %h", got, DW'(want));
      stop_on_error();
    end
  endtask

  task automatic check_wb_status(input logic ack, input logic err, input logic want_err);
    if (ack !== !want_err || err !== want_err) begin
      $display("[ERROR] wb_ack_o/wb_err_o got %h/%h expected %h/%h", ack, err, !want_err,
               want_err);
      stop_on_error();
    end
  endtask

  // Grants are sampled on the rising edge, where the requests are stable
  always @(posedge clk_i) begin : grant_mon
    if (arst_n_i) begin
      for (int c = 0; c < NB; c++) begin
        if (tcdm_resp[c].gnt !== tcdm_req[c].req) begin
          $display("[ERROR] tcdm_resp_o[%0d].gnt got %h expected %h", c, tcdm_resp[c].gnt,
                   tcdm_req[c].req);
          stop_on_error();
        end
        if (tcdm_req[c].req && tcdm_resp[c].gnt) begin
          if (tcdm_req[c].wen) begin
            exp_q[c].push_back(ref_read(chan_idx_t'(c), tcdm_req[c].add));
          end else begin
            model_write(chan_idx_t'(c), tcdm_req[c]);
          end
        end
      end
    end
  end

  // A read granted at one rising edge must show r_valid right after it and only then
  always @(negedge clk_i) begin : resp_cmp
    tcdm_resp_t         want;
    logic [BE_W+DW-1:0] e;
    if (arst_n_i) begin
      for (int c = 0; c < NB; c++) begin
        want = '0;
        e    = '0;
        if (exp_q[c].size() > 0) begin
          e            = exp_q[c].pop_front();
          want.r_valid = 1'b1;
          want.r_data  = e[DW-1:0];
        end
        check_resp(c, tcdm_resp[c], want, e[DW +: BE_W]);
      end
    end
  end

  function automatic int pending();
    int n;
    n = 0;
    for (int c = 0; c < NB; c++) begin
      n += exp_q[c].size();
    end
    return n;
  endfunction

  task automatic drive(input tcdm_req_t [NB-1:0] reqs);
    @(negedge clk_i);
    tcdm_req = reqs;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    @(negedge clk_i);
    tcdm_req = '0;
    while (pending() > 0) begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT) begin
        $display("Timeout while waiting for read responses");
        stop_on_error();
      end
    end
  endtask

  // One Wishbone access, then one idle cycle so that a new order is in place
  task automatic wb_access(input logic we, input logic adr, input logic [DW-1:0] data,
                           output logic [DW-1:0] rdata, output logic ack, output logic err);
    int n;
    n = 0;
    @(negedge clk_i);
    wb_cyc  = 1'b1;
    wb_stb  = 1'b1;
    wb_we   = we;
    wb_adr  = adr;
    wb_wdat = data;
    wb_sel  = '1;
    do begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT) begin
        $display("Timeout: Wishbone access got neither ack nor err");
        stop_on_error();
      end
    end while (!(wb_ack || wb_err));
    // The answer belongs in the cycle right after the strobe
    if (n != 1) begin
      $display("Wishbone answer came %0d cycles after the strobe instead of one", n);
      stop_on_error();
    end
    rdata  = wb_rdat;
    ack    = wb_ack;
    err    = wb_err;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    @(negedge clk_i);
    // Ack and err are pulses of a single cycle
    if (wb_ack || wb_err) begin
      $display("Wishbone answer was held for more than one cycle");
      stop_on_error();
    end
  endtask

  // Every channel reads the same word in the same cycle, sweeping the window
  task automatic read_sweep();
    tcdm_req_t [NB-1:0] reqs;
    for (int w = 0; w < WORDS; w++) begin
      for (int c = 0; c < NB; c++) begin
        reqs[c] = make_req(1'b1, w, '1, '0);
      end
      drive(reqs);
    end
    wait_drain();
  endtask

  initial begin : stim
    tcdm_req_t [NB-1:0] reqs;
    order_t             ident;
    order_t             perm;
    order_t             bad;
    logic [DW-1:0]      rdata;
    logic               ack;
    logic               err;
    logic [31:0]        x;
    int                 ch;

    rnd_state = 32'd97784;
    tcdm_req  = '0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = 1'b0;
    wb_wdat   = '0;
    wb_sel    = '0;
    for (int j = 0; j < NB; j++) begin
      ident[j] = chan_idx_t'(j);
    end
    model_order = ident;
    for (int b = 0; b < NB; b++) begin
      for (int w = 0; w < `HWPE_BANK_WORDS; w++) begin
        model_vld[b][w] = '0;
      end
    end
    arst_n_i = 1'b1;
    #5 arst_n_i = 1'b0;
    repeat (5) @(negedge clk_i);
    arst_n_i = 1'b1;

    // Identity order after reset; address 1 reads zero and refuses writes
    wb_access(1'b0, 1'b0, '0, rdata, ack, err);
    check_wb_status(ack, err, 1'b0);
    check_order(rdata, ident);
    wb_access(1'b0, 1'b1, '0, rdata, ack, err);
    check_wb_status(ack, err, 1'b0);
    check_order(rdata, '0);
    wb_access(1'b1, 1'b1, '1, rdata, ack, err);
    check_wb_status(ack, err, 1'b1);
    read_sweep();

    // Full words first, then random byte writes merged on top, then reads
    for (int w = 0; w < WORDS; w++) begin
      for (int c = 0; c < NB; c++) begin
        reqs[c] = make_req(1'b0, w, '1, xorshift());
      end
      drive(reqs);
    end
    for (int i = 0; i < 48; i++) begin
      reqs         = '0;
      ch           = int'(xorshift() % 32'(NB));
      reqs[ch]     = rand_req();
      reqs[ch].wen = (i >= 24);
      drive(reqs);
    end
    wait_drain();

    // A new permutation moves each channel onto another bank's data
    perm = random_perm();
    wb_access(1'b1, 1'b0, DW'(perm), rdata, ack, err);
    check_wb_status(ack, err, 1'b0);
    model_order = perm;
    wb_access(1'b0, 1'b0, '0, rdata, ack, err);
    check_wb_status(ack, err, 1'b0);
    check_order(rdata, perm);
    read_sweep();

    // Duplicate channel index, rejected with the old order kept
    bad    = perm;
    bad[0] = perm[1];
    wb_access(1'b1, 1'b0, DW'(bad), rdata, ack, err);
    check_wb_status(ack, err, 1'b1);
    wb_access(1'b0, 1'b0, '0, rdata, ack, err);
    check_wb_status(ack, err, 1'b0);
    check_order(rdata, perm);
    read_sweep();

    // Back-to-back mixed traffic on all channels, about one slot in four idle
    for (int i = 0; i < 64; i++) begin
      for (int c = 0; c < NB; c++) begin
        x       = xorshift();
        reqs[c] = rand_req();
        if (x[1:0] == 2'b00) begin
          reqs[c] = '0;
        end
      end
      drive(reqs);
    end
    wait_drain();

    repeat (2) @(negedge clk_i);
    $display("Verification passed");
    $finish;
  end

endmodule

// File: design/tcdm_cluster_top.sv
`include "hwpe_cfg.svh"

// Memory cluster: order register, static crossbar and one bank per channel
module tcdm_cluster_top (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,

  // Streamer side TCDM channels
  input  hwpe_pkg::tcdm_req_t  [`HWPE_NB_CHAN-1:0] tcdm_req_i,
  output hwpe_pkg::tcdm_resp_t [`HWPE_NB_CHAN-1:0] tcdm_resp_o,

  // Configuration slave
  input  logic                                     wb_cyc_i,
  input  logic                                     wb_stb_i,
  input  logic                                     wb_we_i,
  input  logic                                     wb_adr_i,
  input  logic [`HWPE_DATA_W-1:0]                  wb_dat_i,
  input  logic [`HWPE_DATA_W/8-1:0]                wb_sel_i,
  output logic [`HWPE_DATA_W-1:0]                  wb_dat_o,
  output logic                                     wb_ack_o,
  output logic                                     wb_err_o
);

  import hwpe_pkg::*;

  order_t                          order;
  tcdm_req_t  [`HWPE_NB_CHAN-1:0]  bank_req;
  tcdm_resp_t [`HWPE_NB_CHAN-1:0]  bank_resp;

  order_regs u_order_regs (
    .clk_i    ( clk_i    ),
    .arst_n_i ( arst_n_i ),
    .wb_cyc_i ( wb_cyc_i ),
    .wb_stb_i ( wb_stb_i ),
    .wb_we_i  ( wb_we_i  ),
    .wb_adr_i ( wb_adr_i ),
    .wb_dat_i ( wb_dat_i ),
    .wb_sel_i ( wb_sel_i ),
    .wb_dat_o ( wb_dat_o ),
    .wb_ack_o ( wb_ack_o ),
    .wb_err_o ( wb_err_o ),
    .order_o  ( order    )
  );

  tcdm_reorder_static u_reorder (
    .clk_i      ( clk_i       ),
    .order_i    ( order       ),
    .in_req_i   ( tcdm_req_i  ),
    .in_resp_o  ( tcdm_resp_o ),
    .out_req_o  ( bank_req    ),
    .out_resp_i ( bank_resp   )
  );

  // Bank j serves whichever channel order[j] selects
  for (genvar j = 0; j < `HWPE_NB_CHAN; j++) begin : gen_bank
    tcdm_bank u_bank (
      .clk_i    ( clk_i        ),
      .arst_n_i ( arst_n_i     ),
      .req_i    ( bank_req[j]  ),
      .resp_o   ( bank_resp[j] )
    );
  end

endmodule

// File: design/tcdm_bank.sv
`include "hwpe_cfg.svh"

// Single-port memory bank on the TCDM protocol
// Never stalls, so gnt follows req, and a read returns one cycle later
module tcdm_bank (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  hwpe_pkg::tcdm_req_t   req_i,
  output hwpe_pkg::tcdm_resp_t  resp_o
);

  // Byte offset bits dropped from the address, and word index bits kept
  localparam int unsigned OFF_W = $clog2(`HWPE_DATA_W/8);
  localparam int unsigned IDX_W = $clog2(`HWPE_BANK_WORDS);

  logic [`HWPE_DATA_W-1:0]  mem [`HWPE_BANK_WORDS];
  logic [IDX_W-1:0]         idx;
  logic [`HWPE_DATA_W-1:0]  r_data_q;
  logic                     r_valid_q;

  assign idx = req_i.add[OFF_W +: IDX_W];

  // wen low is a write; only the lanes with be set are changed
  always_ff @(posedge clk_i) begin : write_ff
    if (req_i.req && !req_i.wen) begin
      for (int b = 0; b < `HWPE_DATA_W/8; b++) begin
        if (req_i.be[b]) begin
          mem[idx][8*b +: 8] <= req_i.data[8*b +: 8];
        end
      end
    end
  end

  // Read data is held until the next read
  always_ff @(posedge clk_i) begin : read_ff
    if (req_i.req && req_i.wen) begin
      r_data_q <= mem[idx];
    end
  end

  // One pulse per accepted read, writes give no response
  always_ff @(posedge clk_i or negedge arst_n_i) begin : valid_ff
    if (!arst_n_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= req_i.req & req_i.wen;
    end
  end

  assign resp_o.gnt     = req_i.req;
  assign resp_o.r_data  = r_data_q;
  assign resp_o.r_valid = r_valid_q;

  // Banks are not interleaved, so upper address bits from the streamer
  // must stay inside this bank once routed through the crossbar
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   req_i.req |-> (req_i.add >> OFF_W) < `HWPE_BANK_WORDS)
    else $error("bank address out of range: %h", req_i.add);

endmodule

// File: design/order_regs.sv
`include "hwpe_cfg.svh"

// Wishbone classic slave holding the channel order word
// Address 0 is the order word, address 1 reads as zero and rejects writes
// Every access is answered one cycle after it is seen, with ack or with err
module order_regs (
  input  logic                          clk_i,
  input  logic                          arst_n_i,

  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic                          wb_adr_i,
  input  logic [`HWPE_DATA_W-1:0]       wb_dat_i,
  input  logic [`HWPE_DATA_W/8-1:0]     wb_sel_i,
  output logic [`HWPE_DATA_W-1:0]       wb_dat_o,
  output logic                          wb_ack_o,
  output logic                          wb_err_o,

  output hwpe_pkg::order_t              order_o
);

  import hwpe_pkg::*;

  localparam int unsigned ORDER_W = $bits(order_t);

  logic                     access;
  logic                     wr_bad;
  logic                     wr_good;
  logic [`HWPE_DATA_W-1:0]  order_word;
  logic [`HWPE_DATA_W-1:0]  merged;
  order_t                   cand;
  order_t                   order_q;
  order_t                   pend_q;
  logic                     pend_valid_q;
  logic                     ack_q;
  logic                     err_q;
  logic [`HWPE_DATA_W-1:0]  dat_q;

  // The master keeps stb up during the response cycle, so a new access is
  // only taken once the previous answer has gone
  assign access = wb_cyc_i & wb_stb_i & ~ack_q & ~err_q;

  // Current order, zero-extended to a bus word
  always_comb begin : order_word_comb
    order_word = '0;
    order_word[ORDER_W-1:0] = order_q;
  end

  // Lanes without sel keep their current value
  always_comb begin : merge_comb
    merged = order_word;
    for (int b = 0; b < `HWPE_DATA_W/8; b++) begin
      if (wb_sel_i[b]) begin
        merged[8*b +: 8] = wb_dat_i[8*b +: 8];
      end
    end
  end

  assign cand = merged[ORDER_W-1:0];

  // Writes to the unused address, or of a word that is not a permutation,
  // are refused and leave the order alone
  assign wr_bad  = access & wb_we_i & (wb_adr_i | ~order_is_perm(cand));
  assign wr_good = access & wb_we_i & ~wb_adr_i & order_is_perm(cand);

  always_ff @(posedge clk_i or negedge arst_n_i) begin : ctrl_ff
    if (!arst_n_i) begin
      ack_q        <= 1'b0;
      err_q        <= 1'b0;
      pend_valid_q <= 1'b0;
      // Identity mapping, bank j serves channel j
      for (int j = 0; j < `HWPE_NB_CHAN; j++) begin
        order_q[j] <= chan_idx_t'(j);
      end
    end else begin
      ack_q        <= access & ~wr_bad;
      err_q        <= wr_bad;
      pend_valid_q <= wr_good;
      // The accepted word is applied at the end of the ack cycle
      if (pend_valid_q) begin
        order_q <= pend_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin : data_ff
    if (wr_good) begin
      pend_q <= cand;
    end
    if (access && !wb_we_i) begin
      dat_q <= wb_adr_i ? '0 : order_word;
    end
  end

  assign wb_dat_o = dat_q;
  assign wb_ack_o = ack_q;
  assign wb_err_o = err_q;
  assign order_o  = order_q;

  assert property (@(posedge clk_i) disable iff (!arst_n_i) !(ack_q && err_q))
    else $error("ack and err raised together");

  // Every answer belongs to a strobe seen one cycle earlier
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   (ack_q || err_q) |-> $past(wb_cyc_i && wb_stb_i))
    else $error("Wishbone answer without a preceding strobe");

endmodule

// File: reorder/tcdm_reorder_static.sv
`include "hwpe_cfg.svh"

// Static channel permutation between the streamer side and the banks
// The order word is treated as static while traffic is in flight, so the
// crossbar is purely combinational and adds no latency in either direction
module tcdm_reorder_static (
  // Sampling clock for the permutation check only
  input  logic                                     clk_i,

  input  hwpe_pkg::order_t                         order_i,

  // Streamer side
  input  hwpe_pkg::tcdm_req_t  [`HWPE_NB_CHAN-1:0] in_req_i,
  output hwpe_pkg::tcdm_resp_t [`HWPE_NB_CHAN-1:0] in_resp_o,

  // Bank side
  output hwpe_pkg::tcdm_req_t  [`HWPE_NB_CHAN-1:0] out_req_o,
  input  hwpe_pkg::tcdm_resp_t [`HWPE_NB_CHAN-1:0] out_resp_i
);

  import hwpe_pkg::*;

  // Bank j takes the whole request of the channel that order_i[j] names
  // Since order_i is a permutation, every channel reaches exactly one bank
  always_comb begin : mux_req_comb
    for (int j = 0; j < `HWPE_NB_CHAN; j++) begin
      out_req_o[j] = in_req_i[order_i[j]];
    end
  end

  // Responses travel the reverse way
  // A channel that no bank points at sees gnt, r_valid and r_data all low,
  // which can only happen with a broken order word
  always_comb begin : mux_resp_comb
    in_resp_o = '0;
    for (int j = 0; j < `HWPE_NB_CHAN; j++) begin
      in_resp_o[order_i[j]] = out_resp_i[j];
    end
  end

  // A duplicated channel index would route one streamer to two banks and
  // leave another with no bank at all, so the order register must never
  // pass such a word down here
  assert property (@(posedge clk_i) order_is_perm(order_i))
    else $error("order_i is not a permutation: %h", order_i);

endmodule

// File: common/hwpe_pkg.sv
`include "hwpe_cfg.svh"

package hwpe_pkg;

  // Request from a streamer channel, wen high means read
  typedef struct packed {
    logic                       req;
    logic [`HWPE_ADDR_W-1:0]    add;
    logic                       wen;
    logic [`HWPE_DATA_W/8-1:0]  be;
    logic [`HWPE_DATA_W-1:0]    data;
  } tcdm_req_t;

  // Response returned to a streamer channel
  typedef struct packed {
    logic                       gnt;
    logic [`HWPE_DATA_W-1:0]    r_data;
    logic                       r_valid;
  } tcdm_resp_t;

  typedef logic [$clog2(`HWPE_NB_CHAN)-1:0] chan_idx_t;

  // Field j names the input channel served by bank j
  typedef chan_idx_t [`HWPE_NB_CHAN-1:0] order_t;

  // True when every channel index appears exactly once in the order word
  function automatic logic order_is_perm(order_t ord);
    logic [`HWPE_NB_CHAN-1:0] seen;
    seen = '0;
    for (int j = 0; j < `HWPE_NB_CHAN; j++) begin
      seen[ord[j]] = 1'b1;
    end
    return &seen;
  endfunction

endpackage

// File: common/hwpe_cfg.svh
`ifndef HWPE_CFG_SVH
`define HWPE_CFG_SVH

// Number of streamer channels, which is also the number of memory banks
`define HWPE_NB_CHAN 4

// Depth of each bank in data words
`define HWPE_BANK_WORDS 64

// Byte address width carried on the TCDM request
`define HWPE_ADDR_W 32

// Data width of the TCDM and Wishbone data paths
// Byte enables and Wishbone selects are one bit per byte of this width
`define HWPE_DATA_W 32

`endif
